//--- source/corr_params.svh
// --------------------
// Correlator sizing
// --------------------

`ifndef CORR_PARAMS_SVH
`define CORR_PARAMS_SVH

// Channels, and also baselines, since each channel starts one pair.
`define CORR_NUM_INPUTS 4

`define CORR_SAMPLE_WIDTH 2 // Low-resolution sampler output.

// Lags per baseline, which is also the delay line depth.
`define CORR_NUM_LAGS 4

`define CORR_ACC_WIDTH 12 // Per half of the complex value.

`endif

//--- source/corr_sample_pkg.sv
// --------------------
// Sample types
// --------------------

`include "corr_params.svh"

package corr_sample_pkg;

	// One unsigned sampler output.
	typedef logic [`CORR_SAMPLE_WIDTH-1:0] sample_t;

	// Delay line taps. Element 0 is the newest sample, element k is k strobes old.
	typedef sample_t [`CORR_NUM_LAGS-1:0] tap_vec_t;

	// All channels as presented on one sample strobe.
	typedef sample_t [`CORR_NUM_INPUTS-1:0] channel_bundle_t;

endpackage

//--- source/corr_result_pkg.sv
// --------------------
// Result types
// --------------------

`include "corr_params.svh"

package corr_result_pkg;

	typedef struct packed {
		logic [`CORR_ACC_WIDTH-1:0] re;
		logic [`CORR_ACC_WIDTH-1:0] im;
	} acc_t;

	typedef acc_t [`CORR_NUM_LAGS-1:0] baseline_acc_t; // One entry per lag.

	typedef struct packed {
		logic [$clog2(`CORR_NUM_INPUTS)-1:0] baseline;
		logic [$clog2(`CORR_NUM_LAGS)-1:0]   lag;
	} read_sel_t;

	// Saturated is set when either half sits at full scale.
	typedef struct packed {
		acc_t acc;
		logic saturated;
	} read_result_t;

endpackage

//--- source/sample_delay_line.sv
// --------------------
// Sample delay line
// --------------------

`timescale 1ns/1ps

`include "corr_params.svh"

module sample_delay_line
	import corr_sample_pkg::*;
(
	input  logic     clk,
	input  logic     reset_i,
	input  logic     strobe_i,
	input  sample_t  sample_i,
	output tap_vec_t taps_o
);

	localparam int NUM_LAGS = `CORR_NUM_LAGS;

	tap_vec_t taps_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			taps_q <= '0;
		end else if (strobe_i) begin
			// Oldest sample drops off the top.
			taps_q <= {taps_q[NUM_LAGS-2:0], sample_i};
		end
	end

	assign taps_o = taps_q;

endmodule

//--- source/lag_accumulator.sv
// --------------------
// Baseline lag accumulator
// --------------------

`timescale 1ns/1ps

`include "corr_params.svh"

module lag_accumulator
	import corr_sample_pkg::*;
	import corr_result_pkg::*;
(
	input  logic          clk,
	input  logic          reset_i,
	input  logic          enable_i,
	input  logic          accumulate_i,
	input  sample_t       ref_sample_i,
	input  tap_vec_t      lag_taps_i,
	output baseline_acc_t acc_o
);

	localparam int ACC_W    = `CORR_ACC_WIDTH;
	localparam int PROD_W   = 2 * `CORR_SAMPLE_WIDTH;
	localparam int NUM_LAGS = `CORR_NUM_LAGS;

	baseline_acc_t acc_q;
	tap_vec_t      inv_taps;

	logic [PROD_W-1:0] prod_re [NUM_LAGS];
	logic [PROD_W-1:0] prod_im [NUM_LAGS];

	// Add a product, clamping at full scale.
	function automatic logic [ACC_W-1:0] sat_add(
		input logic [ACC_W-1:0]  acc,
		input logic [PROD_W-1:0] prod
	);
		logic [ACC_W:0] sum;
		sum = acc + prod;
		return sum[ACC_W] ? {ACC_W{1'b1}} : sum[ACC_W-1:0];
	endfunction

	// --------------------
	// Products
	// --------------------

	assign inv_taps = ~lag_taps_i; // 3 minus each 2-bit tap.

	always_comb begin
		for (int k = 0; k < NUM_LAGS; k++) begin
			prod_re[k] = ref_sample_i * lag_taps_i[k];
			prod_im[k] = ref_sample_i * inv_taps[k];
		end
	end

	// --------------------
	// Accumulators
	// --------------------

	always_ff @(posedge clk) begin
		if (reset_i || !enable_i) begin
			acc_q <= '0;
		end else if (accumulate_i) begin
			for (int k = 0; k < NUM_LAGS; k++) begin
				acc_q[k].re <= sat_add(acc_q[k].re, prod_re[k]);
				acc_q[k].im <= sat_add(acc_q[k].im, prod_im[k]);
			end
		end
	end

	assign acc_o = acc_q;

	// Counts only grow while the correlator stays enabled.
	for (genvar k = 0; k < NUM_LAGS; k++) begin : g_mono
		a_no_decrease : assert property (
			@(posedge clk) disable iff (reset_i)
			enable_i |=> (acc_q[k].re >= $past(acc_q[k].re)) &&
				(acc_q[k].im >= $past(acc_q[k].im))
		);
	end

endmodule

//--- source/correlator_core.sv
// --------------------
// Correlator core
// --------------------

`timescale 1ns/1ps

`include "corr_params.svh"

module correlator_core
	import corr_sample_pkg::*;
	import corr_result_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset_i,
	input  logic                        enable_i,
	input  logic                        sample_strobe_i,
	input  channel_bundle_t             samples_i,
	input  logic [`CORR_NUM_INPUTS-1:0] channel_mask_i,
	output baseline_acc_t               acc_o [`CORR_NUM_INPUTS]
);

	localparam int NUM_INPUTS = `CORR_NUM_INPUTS;

	tap_vec_t taps [NUM_INPUTS];

	logic                  acc_strobe; // Strobe one cycle late, taps already shifted.
	logic [NUM_INPUTS-1:0] pair_en;
	logic [NUM_INPUTS-1:0] accumulate;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			acc_strobe <= 1'b0;
		end else begin
			acc_strobe <= sample_strobe_i;
		end
	end

	// --------------------
	// Delay lines
	// --------------------

	for (genvar c = 0; c < NUM_INPUTS; c++) begin : g_chan
		sample_delay_line sample_delay_line_i (
			.clk      (clk),
			.reset_i  (reset_i),
			.strobe_i (sample_strobe_i),
			.sample_i (samples_i[c]),
			.taps_o   (taps[c])
		);
	end

	// --------------------
	// Baselines
	// --------------------

	// Baseline b pairs channel b with the next channel, wrapping around.
	for (genvar b = 0; b < NUM_INPUTS; b++) begin : g_base
		localparam int PEER = (b + 1) % NUM_INPUTS;

		assign pair_en[b]    = channel_mask_i[b] & channel_mask_i[PEER];
		assign accumulate[b] = acc_strobe & pair_en[b]; // Masked pairs simply hold.

		lag_accumulator lag_accumulator_i (
			.clk          (clk),
			.reset_i      (reset_i),
			.enable_i     (enable_i),
			.accumulate_i (accumulate[b]),
			.ref_sample_i (taps[b][0]),
			.lag_taps_i   (taps[PEER]),
			.acc_o        (acc_o[b])
		);

		// A masked pair keeps its values while enabled.
		a_masked_hold : assert property (
			@(posedge clk) disable iff (reset_i)
			enable_i && !pair_en[b] |=> acc_o[b] == $past(acc_o[b])
		);
	end

endmodule

//--- source/result_readout.sv
// --------------------
// Result readout
// --------------------

`timescale 1ns/1ps

`include "corr_params.svh"

module result_readout
	import corr_result_pkg::*;
(
	input  logic          clk,
	input  logic          reset_i,
	input  read_sel_t     read_sel_i,
	input  baseline_acc_t acc_i [`CORR_NUM_INPUTS],
	output read_result_t  read_o
);

	localparam logic [`CORR_ACC_WIDTH-1:0] ACC_MAX = {`CORR_ACC_WIDTH{1'b1}};

	acc_t sel_acc;

	assign sel_acc = acc_i[read_sel_i.baseline][read_sel_i.lag];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			read_o <= '0;
		end else begin
			read_o.acc       <= sel_acc;
			read_o.saturated <= (sel_acc.re == ACC_MAX) || (sel_acc.im == ACC_MAX);
		end
	end

endmodule

//--- source/correlator_top.sv
// --------------------
// Lag correlator top
// --------------------

`timescale 1ns/1ps

`include "corr_params.svh"

module correlator_top
	import corr_sample_pkg::*;
	import corr_result_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset_i,
	input  logic                        enable_i,
	input  logic                        sample_strobe_i,
	input  channel_bundle_t             samples_i,
	input  logic [`CORR_NUM_INPUTS-1:0] channel_mask_i,
	input  read_sel_t                   read_sel_i,
	output read_result_t                read_o
);

	baseline_acc_t acc [`CORR_NUM_INPUTS]; // All baselines, all lags.

	correlator_core correlator_core_i (
		.clk             (clk),
		.reset_i         (reset_i),
		.enable_i        (enable_i),
		.sample_strobe_i (sample_strobe_i),
		.samples_i       (samples_i),
		.channel_mask_i  (channel_mask_i),
		.acc_o           (acc)
	);

	result_readout result_readout_i (
		.clk        (clk),
		.reset_i    (reset_i),
		.read_sel_i (read_sel_i),
		.acc_i      (acc),
		.read_o     (read_o)
	);

endmodule

//--- verif/corr_tb_util.svh
// --------------------
// Testbench helpers
// --------------------

`ifndef CORR_TB_UTIL_SVH
`define CORR_TB_UTIL_SVH

// Galois LFSR, 16 bits, taps 16 14 13 11.
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
	return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// One LFSR step for every bit taken.
function automatic int unsigned rand_bits(input int n);
	int unsigned value;
	value = 0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		value = (value << 1) | lfsr_state[0];
	end
	return value;
endfunction

function automatic int clamp_add(input int acc, input int prod);
	return (acc + prod > ACC_MAX) ? ACC_MAX : acc + prod;
endfunction

// --------------------
// Reference model
// --------------------

task automatic model_clear();
	for (int b = 0; b < NUM_INPUTS; b++) begin
		for (int k = 0; k < NUM_LAGS; k++) begin
			model_re[b][k] = 0;
			model_im[b][k] = 0;
		end
	end
endtask

task automatic model_flush_taps();
	for (int c = 0; c < NUM_INPUTS; c++) begin
		for (int k = 0; k < NUM_LAGS; k++) begin
			model_hist[c][k] = 0;
		end
	end
endtask

// One strobe: shift every history, then add the products of each live pair.
task automatic model_strobe(input channel_bundle_t s, input logic [3:0] mask, input logic en);
	int peer;
	int ref_s;
	for (int c = 0; c < NUM_INPUTS; c++) begin
		for (int k = NUM_LAGS - 1; k > 0; k--) begin
			model_hist[c][k] = model_hist[c][k-1];
		end
		model_hist[c][0] = s[c];
	end
	if (en) begin
		for (int b = 0; b < NUM_INPUTS; b++) begin
			peer = (b + 1) % NUM_INPUTS;
			ref_s = model_hist[b][0];
			if (mask[b] && mask[peer]) begin
				for (int k = 0; k < NUM_LAGS; k++) begin
					model_re[b][k] = clamp_add(model_re[b][k], ref_s * model_hist[peer][k]);
					model_im[b][k] = clamp_add(model_im[b][k],
						ref_s * (SAMPLE_MAX - model_hist[peer][k]));
				end
			end
		end
	end
endtask

`endif

//--- verif/correlator_tb.sv
// --------------------
// Correlator testbench
// --------------------

`timescale 1ns/1ps

`include "corr_params.svh"

module correlator_tb
	import corr_sample_pkg::*;
	import corr_result_pkg::*;
();

	localparam int NUM_INPUTS      = `CORR_NUM_INPUTS;
	localparam int NUM_LAGS        = `CORR_NUM_LAGS;
	localparam int ACC_W           = `CORR_ACC_WIDTH;
	localparam int SAMPLE_W        = `CORR_SAMPLE_WIDTH;
	localparam int SEL_B_W         = $clog2(`CORR_NUM_INPUTS);
	localparam int SEL_L_W         = $clog2(`CORR_NUM_LAGS);
	localparam int ACC_MAX         = (1 << ACC_W) - 1;
	localparam int SAMPLE_MAX      = (1 << SAMPLE_W) - 1;
	localparam int SETTLE_CYCLES   = 3;
	localparam int SAT_STROBES     = 470; // 470 * 9 is past full scale.
	localparam int WATCHDOG_CYCLES = 20000;

	logic                  clk;
	logic                  reset_i;
	logic                  enable_i;
	logic                  sample_strobe_i;
	channel_bundle_t       samples_i;
	logic [NUM_INPUTS-1:0] channel_mask_i;
	read_sel_t             read_sel_i;
	read_result_t          read_o;

	logic [15:0]  lfsr_state = 16'd22617;
	int           model_hist [NUM_INPUTS][NUM_LAGS];
	int           model_re   [NUM_INPUTS][NUM_LAGS];
	int           model_im   [NUM_INPUTS][NUM_LAGS];
	read_result_t snap       [NUM_INPUTS][NUM_LAGS]; // Last value read per entry.
	read_result_t held       [NUM_INPUTS][NUM_LAGS];
	string        test_name;

	`include "corr_tb_util.svh"

	correlator_top correlator_top_i (
		.clk             (clk),
		.reset_i         (reset_i),
		.enable_i        (enable_i),
		.sample_strobe_i (sample_strobe_i),
		.samples_i       (samples_i),
		.channel_mask_i  (channel_mask_i),
		.read_sel_i      (read_sel_i),
		.read_o          (read_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin : watchdog
		for (int i = 0; i < WATCHDOG_CYCLES; i++) begin
			@(posedge clk);
		end
		fail_text("simulation did not finish within the cycle limit");
	end

	task automatic fail_value(input string what, input longint exp, input longint act);
		$display("FAIL %s: expected %0h actual %0h", what, exp, act);
		$display("RESULT: FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic fail_text(input string what);
		$display("Error in %s: %s", test_name, what);
		$display("RESULT: FAIL");
		$fatal(1, "check failed");
	endtask

	// --------------------
	// Concurrent checks
	// --------------------

	a_disable_clears : assert property (
		@(posedge clk) disable iff (reset_i)
		!enable_i |-> ##2 (read_o.acc == '0)
	) else fail_value($sformatf("%s disable clear", test_name), 0, $sampled(read_o.acc));

	// --------------------
	// Stimulus
	// --------------------

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			tick();
		end
	endtask

	task automatic apply_strobe(input channel_bundle_t s);
		samples_i = s;
		sample_strobe_i = 1'b1;
		model_strobe(s, channel_mask_i, enable_i);
		tick();
		sample_strobe_i = 1'b0;
		samples_i = '0;
	endtask

	// A zero gap gives back to back strobes.
	task automatic random_strobes(input int n);
		channel_bundle_t s;
		int gap;
		for (int i = 0; i < n; i++) begin
			for (int c = 0; c < NUM_INPUTS; c++) begin
				s[c] = SAMPLE_W'(rand_bits(SAMPLE_W));
			end
			apply_strobe(s);
			gap = rand_bits(2);
			wait_cycles(gap);
		end
	endtask

	task automatic pulse_enable_low();
		wait_cycles(SETTLE_CYCLES);
		enable_i = 1'b0;
		model_clear();
		tick();
		enable_i = 1'b1;
	endtask

	task automatic check_entry(input int b, input int k);
		read_result_t exp;
		read_sel_i.baseline = SEL_B_W'(b);
		read_sel_i.lag = SEL_L_W'(k);
		tick();
		exp.acc.re = ACC_W'(model_re[b][k]);
		exp.acc.im = ACC_W'(model_im[b][k]);
		exp.saturated = (model_re[b][k] == ACC_MAX) || (model_im[b][k] == ACC_MAX);
		snap[b][k] = read_o;
		assert (read_o == exp)
			else fail_value($sformatf("%s b%0d lag%0d", test_name, b, k), exp, read_o);
	endtask

	task automatic check_all();
		wait_cycles(SETTLE_CYCLES);
		for (int b = 0; b < NUM_INPUTS; b++) begin
			for (int k = 0; k < NUM_LAGS; k++) begin
				check_entry(b, k);
			end
		end
	endtask

	// Impulse of 3 on channel 1, channel 0 carries 2 once it is lag strobes old.
	task automatic impulse_run(input int lag);
		channel_bundle_t s;
		for (int i = 0; i < NUM_LAGS; i++) begin
			apply_strobe('0);
		end
		pulse_enable_low();
		for (int j = 0; j <= lag; j++) begin
			s = '0;
			if (j == 0) s[1] = 2'd3;
			if (j == lag) s[0] = 2'd2;
			apply_strobe(s);
		end
		for (int i = 0; i < NUM_LAGS; i++) begin
			apply_strobe('0);
		end
		check_all();
		for (int k = 0; k < NUM_LAGS; k++) begin
			assert (snap[0][k].acc.re == ((k == lag) ? 6 : 0))
				else fail_value($sformatf("%s b0 lag%0d re", test_name, k),
					(k == lag) ? 6 : 0, snap[0][k].acc.re);
		end
	endtask

	initial begin
		reset_i = 1'b1;
		enable_i = 1'b0;
		sample_strobe_i = 1'b0;
		samples_i = '0;
		channel_mask_i = '1;
		read_sel_i = '0;
		model_flush_taps();
		model_clear();
		wait_cycles(10);
		reset_i = 1'b0;
		enable_i = 1'b1;

		test_name = "clear_after_reset";
		check_all();
		random_strobes(12);
		test_name = "clear_after_enable";
		pulse_enable_low();
		check_all();

		test_name = "random_accumulation";
		random_strobes(60);
		check_all();

		for (int lag = 0; lag < NUM_LAGS; lag++) begin
			test_name = $sformatf("lag_placement_%0d", lag);
			impulse_run(lag);
		end

		// Channel 2 off freezes baselines 1 and 2.
		test_name = "mask";
		pulse_enable_low();
		random_strobes(20);
		check_all();
		held = snap;
		channel_mask_i = 4'b1011;
		random_strobes(20);
		check_all();
		for (int b = 1; b <= 2; b++) begin
			for (int k = 0; k < NUM_LAGS; k++) begin
				assert (snap[b][k] == held[b][k])
					else fail_value($sformatf("mask hold b%0d lag%0d", b, k),
						held[b][k], snap[b][k]);
			end
		end
		channel_mask_i = '1;

		// Fill the taps with 3 while disabled so the imaginary parts start clean.
		test_name = "saturation";
		wait_cycles(SETTLE_CYCLES);
		enable_i = 1'b0;
		model_clear();
		for (int i = 0; i < NUM_LAGS; i++) begin
			apply_strobe('1);
		end
		wait_cycles(SETTLE_CYCLES);
		enable_i = 1'b1;
		for (int i = 0; i < SAT_STROBES; i++) begin
			apply_strobe('1);
		end
		check_all();
		for (int b = 0; b < NUM_INPUTS; b++) begin
			for (int k = 0; k < NUM_LAGS; k++) begin
				assert (snap[b][k].acc.re == ACC_W'(ACC_MAX) && snap[b][k].acc.im == '0 &&
					snap[b][k].saturated)
					else fail_value($sformatf("saturation b%0d lag%0d", b, k),
						{ACC_W'(ACC_MAX), ACC_W'(0), 1'b1}, snap[b][k]);
			end
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- files.f
+incdir+source
+incdir+verif
source/corr_sample_pkg.sv
source/corr_result_pkg.sv
source/sample_delay_line.sv
source/lag_accumulator.sv
source/correlator_core.sv
source/result_readout.sv
source/correlator_top.sv
verif/correlator_tb.sv
